// ==== bench/ea_tb.sv ====
`timescale 1ns/1ps

module ea_tb;

  logic        clk;
  logic        reset;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [3:0]  wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic        wb_ack;

  typedef struct {
    string          name;
    ea_pkg::ea_op_e op;
    logic [15:0]    a;
    logic [15:0]    b;
    logic           cin;
    logic [15:0]    res;
    logic           cout;
    logic           ovf;
  } case_t;

  case_t  cases[$];
  integer seed;

  ea_top ea_top_inst (
    .clk      (clk),
    .reset    (reset),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  always #5 clk = ~clk;

  // ==========================================================================
  // Checks
  // ==========================================================================
  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "run aborted");
  endtask

  task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] act);
    if (act !== exp)
      abort_run($sformatf("ERR %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp)
      abort_run($sformatf("ERR %s expected %b actual %b", name, exp, act));
  endtask

  task automatic check_op(input string name, input ea_pkg::ea_op_e exp,
                          input ea_pkg::ea_op_e act);
    if (act !== exp)
      abort_run($sformatf("ERR %s expected %0d actual %0d", name, exp, act));
  endtask

  // ==========================================================================
  // Wishbone master
  // ==========================================================================
  task automatic wb_access(input logic we, input logic [1:0] word, input logic [31:0] data,
                           output logic [31:0] rdata);
    int cycles;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = {word, 2'b00};
    wb_dat_w = data;
    cycles   = 0;
    @(posedge clk);
    #1;
    while (!wb_ack) begin
      if (cycles == 20)
        abort_run($sformatf("No ack from the bus for word %0d", word));
      @(posedge clk);
      #1;
      cycles++;
    end
    rdata  = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    @(posedge clk);   // stb low for a cycle
    #1;
  endtask

  task automatic wb_write(input logic [1:0] word, input logic [31:0] data);
    logic [31:0] unused;
    wb_access(1'b1, word, data, unused);
  endtask

  task automatic wb_read(input logic [1:0] word, output logic [31:0] data);
    wb_access(1'b0, word, 32'h0, data);
  endtask

  function automatic logic [31:0] ctrl_word(input ea_pkg::ea_op_e op, input logic cin,
                                            input logic go);
    logic [31:0] w;
    w = '0;
    w[ea_pkg::ctrl_op_lsb +: 2] = op;
    w[ea_pkg::ctrl_cin_bit]     = cin;
    w[ea_pkg::ctrl_go_bit]      = go;
    return w;
  endfunction

  task automatic wait_done(input string name, output logic [31:0] status);
    int polls;
    polls = 0;
    wb_read(ea_pkg::reg_result, status);
    while (!status[ea_pkg::stat_done_bit]) begin
      if (polls == 50)
        abort_run({"Operation ", name, " never reported done"});
      wb_read(ea_pkg::reg_result, status);
      polls++;
    end
  endtask

  task automatic run_op(input string name, input ea_pkg::ea_op_e op, input logic [15:0] a,
                        input logic [15:0] b, input logic cin, output logic [31:0] status);
    wb_write(ea_pkg::reg_opa, {16'h0, a});
    wb_write(ea_pkg::reg_opb, {16'h0, b});
    wb_write(ea_pkg::reg_ctrl, ctrl_word(op, cin, 1'b1));
    wb_read(ea_pkg::reg_result, status);
    check_flag({name, " done cleared"}, 1'b0, status[ea_pkg::stat_done_bit]);
    check_flag({name, " busy set"}, 1'b1, status[ea_pkg::stat_busy_bit]);
    wait_done(name, status);
  endtask

  task automatic check_result(input string name, input logic [31:0] status,
                              input logic [15:0] res, input logic cout, input logic ovf);
    check_word(name, res, status[15:0]);
    check_flag({name, " cout"}, cout, status[ea_pkg::stat_cout_bit]);
    check_flag({name, " ovf"}, ovf, status[ea_pkg::stat_ovf_bit]);
    check_flag({name, " busy"}, 1'b0, status[ea_pkg::stat_busy_bit]);
  endtask

  // Reference behaviour of the four operations
  task automatic model_op(input ea_pkg::ea_op_e op, input logic [15:0] a, input logic [15:0] b,
                          input logic cin, output logic [15:0] res, output logic cout,
                          output logic ovf);
    logic [16:0] sum;
    sum  = {1'b0, a} + {1'b0, b} + {16'h0, cin};
    cout = 1'b0;
    ovf  = 1'b0;
    case (op)
      ea_pkg::op_add: begin
        res  = sum[15:0];
        cout = sum[16];
        ovf  = (a[15] == b[15]) && (res[15] != a[15]);
      end
      ea_pkg::op_and: res = a & b;
      ea_pkg::op_or:  res = a | b;
      default:        res = a ^ b;
    endcase
  endtask

  task automatic add_case(input string name, input ea_pkg::ea_op_e op, input logic [15:0] a,
                          input logic [15:0] b, input logic cin, input logic [15:0] res,
                          input logic cout, input logic ovf);
    case_t c;
    c.name = name;
    c.op   = op;
    c.a    = a;
    c.b    = b;
    c.cin  = cin;
    c.res  = res;
    c.cout = cout;
    c.ovf  = ovf;
    cases.push_back(c);
  endtask

  // ==========================================================================
  // Stimulus
  // ==========================================================================
  initial begin
    logic [31:0] rd;
    logic [31:0] tmp;
    logic [15:0] r_a;
    logic [15:0] r_b;
    logic        r_cin;
    logic [15:0] e_res;
    logic        e_cout;
    logic        e_ovf;
    ea_pkg::ea_op_e r_op;

    clk      = 1'b0;
    reset    = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    seed     = 94;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;

    // Idle state after reset, result register is read only
    wb_read(ea_pkg::reg_result, rd);
    check_result("reset", rd, 16'h0, 1'b0, 1'b0);
    check_flag("reset done", 1'b0, rd[ea_pkg::stat_done_bit]);
    wb_write(ea_pkg::reg_result, 32'hffff_ffff);
    wb_read(ea_pkg::reg_result, rd);
    check_result("result write ignored", rd, 16'h0, 1'b0, 1'b0);

    // Register readback, no go
    wb_write(ea_pkg::reg_opa, 32'h0000_beef);
    wb_write(ea_pkg::reg_opb, 32'h0000_1357);
    wb_write(ea_pkg::reg_ctrl, ctrl_word(ea_pkg::op_or, 1'b1, 1'b0));
    wb_read(ea_pkg::reg_opa, rd);
    check_word("opa readback", 16'hbeef, rd[15:0]);
    wb_read(ea_pkg::reg_opb, rd);
    check_word("opb readback", 16'h1357, rd[15:0]);
    wb_read(ea_pkg::reg_ctrl, rd);
    check_op("ctrl op", ea_pkg::op_or, ea_pkg::ea_op_e'(rd[ea_pkg::ctrl_op_lsb +: 2]));
    check_flag("ctrl cin", 1'b1, rd[ea_pkg::ctrl_cin_bit]);

    add_case("add_zero",   ea_pkg::op_add, 16'h0000, 16'h0000, 1'b0, 16'h0000, 1'b0, 1'b0);
    add_case("add_wrap",   ea_pkg::op_add, 16'hffff, 16'h0001, 1'b0, 16'h0000, 1'b1, 1'b0);
    add_case("add_ripple", ea_pkg::op_add, 16'hffff, 16'h0000, 1'b1, 16'h0000, 1'b1, 1'b0);
    add_case("add_ovf",    ea_pkg::op_add, 16'h7fff, 16'h0001, 1'b0, 16'h8000, 1'b0, 1'b1);
    add_case("add_neg",    ea_pkg::op_add, 16'h8000, 16'h8000, 1'b0, 16'h0000, 1'b1, 1'b1);
    add_case("add_mixed",  ea_pkg::op_add, 16'h1234, 16'h4321, 1'b1, 16'h5556, 1'b0, 1'b0);
    add_case("and_pat",    ea_pkg::op_and, 16'hf0f0, 16'hff00, 1'b0, 16'hf000, 1'b0, 1'b0);
    add_case("and_cin",    ea_pkg::op_and, 16'hffff, 16'hffff, 1'b1, 16'hffff, 1'b0, 1'b0);
    add_case("or_pat",     ea_pkg::op_or,  16'hf0f0, 16'h0f0f, 1'b0, 16'hffff, 1'b0, 1'b0);
    add_case("xor_pat",    ea_pkg::op_xor, 16'haaaa, 16'hffff, 1'b1, 16'h5555, 1'b0, 1'b0);

    foreach (cases[i]) begin
      run_op(cases[i].name, cases[i].op, cases[i].a, cases[i].b, cases[i].cin, rd);
      check_result(cases[i].name, rd, cases[i].res, cases[i].cout, cases[i].ovf);
    end

    // Second go lands while the first add is still running
    wb_write(ea_pkg::reg_opa, 32'h0000_4000);
    wb_write(ea_pkg::reg_opb, 32'h0000_4000);
    wb_write(ea_pkg::reg_ctrl, ctrl_word(ea_pkg::op_add, 1'b1, 1'b1));
    wb_write(ea_pkg::reg_ctrl, ctrl_word(ea_pkg::op_xor, 1'b0, 1'b1));
    wait_done("go_busy", rd);
    wb_write(ea_pkg::reg_opa, 32'h0000_0001);
    wb_read(ea_pkg::reg_opa, rd);
    check_word("go_busy opa", 16'h0001, rd[15:0]);
    wb_read(ea_pkg::reg_ctrl, rd);
    check_op("go_busy op", ea_pkg::op_xor, ea_pkg::ea_op_e'(rd[ea_pkg::ctrl_op_lsb +: 2]));
    check_flag("go_busy cin", 1'b0, rd[ea_pkg::ctrl_cin_bit]);
    check_flag("go_busy go", 1'b0, rd[ea_pkg::ctrl_go_bit]);
    wb_read(ea_pkg::reg_result, rd);
    check_result("go_busy", rd, 16'h8001, 1'b0, 1'b1);
    check_flag("go_busy done", 1'b1, rd[ea_pkg::stat_done_bit]);

    // Seeded random operations
    for (int n = 0; n < 40; n++) begin
      r_a   = 16'($random(seed));
      r_b   = 16'($random(seed));
      tmp   = $random(seed);
      r_op  = ea_pkg::ea_op_e'(tmp[1:0]);
      r_cin = tmp[2];
      model_op(r_op, r_a, r_b, r_cin, e_res, e_cout, e_ovf);
      run_op($sformatf("rand_%0d", n), r_op, r_a, r_b, r_cin, rd);
      check_result($sformatf("rand_%0d", n), rd, e_res, e_cout, e_ovf);
    end

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// ==== hw/ea_bus_regs.sv ====
`timescale 1ns/1ps

module ea_bus_regs (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     wb_cyc,
  input  logic                     wb_stb,
  input  logic                     wb_we,
  input  logic [3:0]               wb_adr,
  input  logic [ea_pkg::bus_w-1:0] wb_dat_w,
  input  logic                     busy,
  input  logic [ea_pkg::bus_w-1:0] status_word,
  output logic [ea_pkg::bus_w-1:0] wb_dat_r,
  output logic                     wb_ack,
  output logic [ea_pkg::data_w-1:0] opa,
  output logic [ea_pkg::data_w-1:0] opb,
  output ea_pkg::ea_op_e           op,
  output logic                     cin,
  output logic                     start
);

  logic                     req;
  logic                     ctrl_wr;
  logic [1:0]               word;
  logic [ea_pkg::bus_w-1:0] rd_data;

  // New request only while no ack is out
  assign req     = wb_cyc & wb_stb & ~wb_ack;
  assign word    = wb_adr[3:2];
  assign ctrl_wr = req & wb_we & (word == ea_pkg::reg_ctrl);

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_ack <= 1'b0;
      start  <= 1'b0;
      op     <= ea_pkg::op_add;
      cin    <= 1'b0;
    end else begin
      wb_ack <= req;
      // Go is dropped while an operation runs
      start  <= ctrl_wr & wb_dat_w[ea_pkg::ctrl_go_bit] & ~busy;
      if (ctrl_wr) begin
        op  <= ea_pkg::ea_op_e'(wb_dat_w[ea_pkg::ctrl_op_lsb +: 2]);
        cin <= wb_dat_w[ea_pkg::ctrl_cin_bit];
      end
    end
  end

  // Operand registers
  always_ff @(posedge clk) begin
    if (req && wb_we) begin
      if (word == ea_pkg::reg_opa)
        opa <= wb_dat_w[ea_pkg::data_w-1:0];
      if (word == ea_pkg::reg_opb)
        opb <= wb_dat_w[ea_pkg::data_w-1:0];
    end
  end

  // ==========================================================================
  // Read path
  // ==========================================================================
  always_comb begin
    rd_data = '0;
    case (word)
      ea_pkg::reg_opa:  rd_data[ea_pkg::data_w-1:0] = opa;
      ea_pkg::reg_opb:  rd_data[ea_pkg::data_w-1:0] = opb;
      ea_pkg::reg_ctrl: begin
        rd_data[ea_pkg::ctrl_op_lsb +: 2]  = op;
        rd_data[ea_pkg::ctrl_cin_bit]      = cin;
      end
      default:          rd_data = status_word;
    endcase
  end

  always_ff @(posedge clk) begin
    if (req && !wb_we)
      wb_dat_r <= rd_data;   // Valid alongside ack
  end

  a_ack_after_req: assert property (@(posedge clk) disable iff (reset)
    wb_ack |-> $past(wb_cyc && wb_stb));

  // Busy comes back from the sequencer a cycle later than the gate
  a_no_start_busy: assert property (@(posedge clk) disable iff (reset)
    start |-> !busy);

endmodule

// ==== hw/ea_core.sv ====
`timescale 1ns/1ps

module ea_core (
  input  logic [15:0] x,
  input  logic [15:0] y,
  input  logic        k,
  input  logic        l,
  input  logic        add,
  input  logic        cin,
  output logic [15:0] alu,
  output logic        cout,
  output logic        ovf
);

  logic [15:0] prop;
  logic [15:0] gen;
  logic [15:0] logic_term;
  logic [15:0] carry;   // Carry into each bit

  // Group generate per level, level 0 is the bitwise term
  logic [15:0] gt [0:4];
  logic [15:0] pt [0:3];

  // ==========================================================================
  // Bit level propagate, generate and logic term
  // ==========================================================================
  assign prop = x | y;
  assign gen  = x & y;

  // k = 0 passes AND, l = 1 passes XOR
  assign logic_term = ((x & y) & {16{~k}}) | ((x ^ y) & {16{l}});

  // Carry-in folded into bit 0 so the tree spans cin as well
  assign gt[0] = {gen[15:1], gen[0] | (prop[0] & cin)};
  assign pt[0] = prop;

  // ==========================================================================
  // Prefix tree, span doubles each level (1, 2, 4, 8)
  // ==========================================================================
  for (genvar lv = 0; lv < 4; lv++) begin : g_level
    for (genvar b = 0; b < 16; b++) begin : g_bit
      if (b >= (1 << lv)) begin : g_merge
        assign gt[lv+1][b] = gt[lv][b] | (pt[lv][b] & gt[lv][b - (1 << lv)]);
        if (lv < 3) begin : g_prop
          assign pt[lv+1][b] = pt[lv][b] & pt[lv][b - (1 << lv)];
        end
      end else begin : g_pass
        assign gt[lv+1][b] = gt[lv][b];   // Already complete down to cin
        if (lv < 3) begin : g_prop
          assign pt[lv+1][b] = pt[lv][b];
        end
      end
    end
  end

  // gt[4][i] is the carry out of bit i
  assign carry = {gt[4][14:0], cin};

  // ==========================================================================
  // Result and flags
  // ==========================================================================
  assign alu  = (carry & {16{add}}) ^ logic_term;
  assign cout = gt[4][15];

  // Operand signs agree, sum sign differs
  assign ovf = (x[15] == y[15]) && (x[15] != (carry[15] ^ x[15] ^ y[15]));

endmodule

// ==== hw/ea_pkg.sv ====
package ea_pkg;

  // ==========================================================================
  // Widths
  // ==========================================================================
  localparam int data_w = 16;   // Operand and result
  localparam int bus_w  = 32;   // Wishbone data

  typedef enum logic [1:0] {
    op_add = 2'd0,
    op_and = 2'd1,
    op_or  = 2'd2,
    op_xor = 2'd3
  } ea_op_e;

  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_done = 2'd2
  } ea_state_e;

  // ==========================================================================
  // Register map, word index on wb_adr[3:2]
  // ==========================================================================
  localparam logic [1:0] reg_opa    = 2'd0;
  localparam logic [1:0] reg_opb    = 2'd1;
  localparam logic [1:0] reg_ctrl   = 2'd2;
  localparam logic [1:0] reg_result = 2'd3;   // Read only

  // Control word
  localparam int ctrl_op_lsb  = 0;   // 2-bit opcode
  localparam int ctrl_cin_bit = 2;
  localparam int ctrl_go_bit  = 8;   // Write only, reads as 0

  // Result word, result itself in the low data_w bits
  localparam int stat_cout_bit = 16;
  localparam int stat_ovf_bit  = 17;
  localparam int stat_busy_bit = 18;
  localparam int stat_done_bit = 19;

endpackage

// ==== hw/ea_sequencer.sv ====
`timescale 1ns/1ps

module ea_sequencer (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      start,
  input  logic [ea_pkg::data_w-1:0] opa,
  input  logic [ea_pkg::data_w-1:0] opb,
  input  ea_pkg::ea_op_e            op,
  input  logic                      cin,
  output logic                      busy,
  output logic                      result_valid,
  output logic [ea_pkg::data_w-1:0] res,
  output logic                      cout,
  output logic                      ovf
);

  ea_pkg::ea_state_e state;

  logic                      k_ctl;
  logic                      l_ctl;
  logic                      add_ctl;
  logic [ea_pkg::data_w-1:0] core_alu;
  logic                      core_cout;
  logic                      core_ovf;

  // Opcode to core controls
  always_comb begin
    k_ctl   = 1'b1;
    l_ctl   = 1'b1;
    add_ctl = 1'b0;
    case (op)
      ea_pkg::op_add: add_ctl = 1'b1;   // Sum is XOR plus carries
      ea_pkg::op_and: begin
        k_ctl = 1'b0;
        l_ctl = 1'b0;
      end
      ea_pkg::op_or:  k_ctl = 1'b0;     // AND | XOR
      default:        ;                 // XOR
    endcase
  end

  ea_core ea_core_inst (
    .x    (opa),
    .y    (opb),
    .k    (k_ctl),
    .l    (l_ctl),
    .add  (add_ctl),
    .cin  (cin),
    .alu  (core_alu),
    .cout (core_cout),
    .ovf  (core_ovf)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ea_pkg::st_idle;
    end else begin
      case (state)
        ea_pkg::st_idle: if (start) state <= ea_pkg::st_calc;
        ea_pkg::st_calc: state <= ea_pkg::st_done;
        default:         state <= ea_pkg::st_idle;
      endcase
    end
  end

  // Flags only mean something for an add
  always_ff @(posedge clk) begin
    if (state == ea_pkg::st_calc) begin
      res  <= core_alu;
      cout <= core_cout & add_ctl;
      ovf  <= core_ovf & add_ctl;
    end
  end

  assign busy         = (state != ea_pkg::st_idle);
  assign result_valid = (state == ea_pkg::st_done);

  a_valid_timing: assert property (@(posedge clk) disable iff (reset)
    result_valid |-> $past(start, 2) && $past(state == ea_pkg::st_calc));

endmodule

// ==== hw/ea_status.sv ====
`timescale 1ns/1ps

module ea_status (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      start,
  input  logic                      result_valid,
  input  logic [ea_pkg::data_w-1:0] res,
  input  logic                      cout,
  input  logic                      ovf,
  input  logic                      busy_in,
  output logic [ea_pkg::bus_w-1:0]  status_word
);

  logic [ea_pkg::data_w-1:0] res_q;
  logic                      cout_q;
  logic                      ovf_q;
  logic                      done_q;

  // ==========================================================================
  // Result and flag registers
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      res_q  <= '0;
      cout_q <= 1'b0;
      ovf_q  <= 1'b0;
      done_q <= 1'b0;
    end else begin
      if (result_valid) begin
        res_q  <= res;
        cout_q <= cout;
        ovf_q  <= ovf;
        done_q <= 1'b1;
      end else if (start) begin
        done_q <= 1'b0;   // Stays clear until the new result lands
      end
    end
  end

  // Readback word
  always_comb begin
    status_word                        = '0;
    status_word[ea_pkg::data_w-1:0]    = res_q;
    status_word[ea_pkg::stat_cout_bit] = cout_q;
    status_word[ea_pkg::stat_ovf_bit]  = ovf_q;
    status_word[ea_pkg::stat_busy_bit] = busy_in;
    status_word[ea_pkg::stat_done_bit] = done_q;
  end

  // Done never overlaps a running operation
  a_done_not_busy: assert property (@(posedge clk) disable iff (reset)
    !(done_q && busy_in));

endmodule

// ==== hw/ea_top.sv ====
`timescale 1ns/1ps

module ea_top (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     wb_cyc,
  input  logic                     wb_stb,
  input  logic                     wb_we,
  input  logic [3:0]               wb_adr,
  input  logic [ea_pkg::bus_w-1:0] wb_dat_w,
  output logic [ea_pkg::bus_w-1:0] wb_dat_r,
  output logic                     wb_ack
);

  logic [ea_pkg::data_w-1:0] opa;
  logic [ea_pkg::data_w-1:0] opb;
  ea_pkg::ea_op_e            op;
  logic                      cin;
  logic                      start;
  logic                      busy;
  logic                      result_valid;
  logic [ea_pkg::data_w-1:0] res;
  logic                      cout;
  logic                      ovf;
  logic [ea_pkg::bus_w-1:0]  status_word;

  // Bus side
  ea_bus_regs ea_bus_regs_inst (
    .clk         (clk),
    .reset       (reset),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_w    (wb_dat_w),
    .busy        (busy),
    .status_word (status_word),
    .wb_dat_r    (wb_dat_r),
    .wb_ack      (wb_ack),
    .opa         (opa),
    .opb         (opb),
    .op          (op),
    .cin         (cin),
    .start       (start)
  );

  ea_sequencer ea_sequencer_inst (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .opa          (opa),
    .opb          (opb),
    .op           (op),
    .cin          (cin),
    .busy         (busy),
    .result_valid (result_valid),
    .res          (res),
    .cout         (cout),
    .ovf          (ovf)
  );

  // Readback side
  ea_status ea_status_inst (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .result_valid (result_valid),
    .res          (res),
    .cout         (cout),
    .ovf          (ovf),
    .busy_in      (busy),
    .status_word  (status_word)
  );

endmodule

// ==== list.f ====
hw/ea_pkg.sv
hw/ea_core.sv
hw/ea_bus_regs.sv
hw/ea_sequencer.sv
hw/ea_status.sv
hw/ea_top.sv
bench/ea_tb.sv
